//--- source/synth_pkg.sv
package synth_pkg;

	// pitch and loudness widths
	localparam int PITCH_W = 6;
	localparam int LEVEL_W = 4;

	// lfsr start value after reset
	localparam logic [15:0] LFSR_SEED = 16'h0001;

	// effect select, as driven on fx_sel
	typedef enum logic [1:0] {
		fx_none,
		fx_porta,
		fx_vibrato,
		fx_slide
	} fx_mode_t;

	// envelope phases
	typedef enum logic [1:0] {
		env_idle,
		env_attack,
		env_sustain,
		env_decay
	} env_state_t;

	// level increment per note step during attack
	function automatic logic [LEVEL_W-1:0] attack_step(input logic [1:0] atk);
		case (atk)
			2'd0: return 4'd15;
			2'd1: return 4'd8;
			2'd2: return 4'd4;
			default: return 4'd2;
		endcase
	endfunction

	// level decrement per note step during decay
	function automatic logic [LEVEL_W-1:0] decay_step(input logic [1:0] dec);
		case (dec)
			2'd0: return 4'd15;
			2'd1: return 4'd4;
			2'd2: return 4'd2;
			default: return 4'd1;
		endcase
	endfunction

endpackage

//--- source/note_fx.sv
module note_fx
	import synth_pkg::*;
(
	input  logic               base_freq,
	input  logic               rst_n,
	input  logic [PITCH_W-1:0] note_in,
	input  logic               note_clk,
	input  logic               note_rst,
	input  fx_mode_t           fx_sel,
	input  logic [1:0]         fx_opt_a,
	input  logic [1:0]         fx_opt_b,
	output logic [PITCH_W-1:0] pitch
);

	localparam logic [PITCH_W-1:0] PITCH_MAX = '1;

	// effect select, taken one cycle late
	fx_mode_t fx_q;
	// note steps since the last effect step
	logic [1:0] step_cnt;
	// vibrato phase: +depth, 0, -depth, 0
	logic [1:0] vib_phase;
	logic [PITCH_W-1:0] pitch_q;
	logic fx_step;
	logic signed [PITCH_W+1:0] vib_off;
	logic signed [PITCH_W+1:0] vib_sum;
	logic [PITCH_W-1:0] vib_pitch;

	// effect acts once every fx_opt_a+1 note steps
	assign fx_step = note_clk && (step_cnt == fx_opt_a);

	// vibrato target, note plus phase offset, clamped
	always_comb
	begin
		case (vib_phase)
			2'd0: vib_off = $signed({{PITCH_W{1'b0}}, fx_opt_b});
			2'd2: vib_off = -$signed({{PITCH_W{1'b0}}, fx_opt_b});
			default: vib_off = '0;
		endcase
		vib_sum = $signed({2'b00, note_in}) + vib_off;
		if (vib_sum < 0)
			vib_pitch = '0;
		else if (vib_sum > $signed({2'b00, PITCH_MAX}))
			vib_pitch = PITCH_MAX;
		else
			vib_pitch = vib_sum[PITCH_W-1:0];
	end

	always_ff @(posedge base_freq)
	begin
		if (!rst_n)
		begin
			fx_q <= fx_none;
			step_cnt <= '0;
			vib_phase <= '0;
			pitch_q <= '0;
		end
		else
		begin
			fx_q <= fx_sel;
			if (note_rst)
			begin
				// new note, restart the effect
				pitch_q <= note_in;
				step_cnt <= '0;
				vib_phase <= '0;
			end
			else
			begin
				if (note_clk)
					step_cnt <= fx_step ? 2'd0 : step_cnt + 2'd1;
				case (fx_q)
					fx_porta:
					begin
						// glide one step toward the new note
						if (fx_step && pitch_q < note_in)
							pitch_q <= pitch_q + 1'b1;
						else if (fx_step && pitch_q > note_in)
							pitch_q <= pitch_q - 1'b1;
					end
					fx_vibrato:
					begin
						if (fx_step)
						begin
							pitch_q <= vib_pitch;
							vib_phase <= vib_phase + 2'd1;
						end
					end
					fx_slide:
					begin
						// bit 0 of opt b picks the direction, saturating
						if (fx_step && fx_opt_b[0] && pitch_q != PITCH_MAX)
							pitch_q <= pitch_q + 1'b1;
						else if (fx_step && !fx_opt_b[0] && pitch_q != '0)
							pitch_q <= pitch_q - 1'b1;
					end
					default:
						pitch_q <= note_in;
				endcase
			end
		end
	end

	assign pitch = pitch_q;

endmodule

//--- source/pitch_divider.sv
module pitch_divider
	import synth_pkg::*;
#(
	parameter int unsigned DIV_SCALE = 64
)
(
	input  logic               base_freq,
	input  logic               rst_n,
	input  logic [PITCH_W-1:0] pitch,
	output logic               shift_tick
);

	// longest period is 64 pitch steps
	localparam int CNT_W = $clog2((1 << PITCH_W) * DIV_SCALE);

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] reload;
	logic [PITCH_W:0] span;
	logic [PITCH_W-1:0] pitch_q;
	logic tick_q;

	// higher pitch, shorter period: (64 - pitch) * DIV_SCALE cycles
	assign span = (PITCH_W+1)'(1 << PITCH_W) - {1'b0, pitch};
	assign reload = CNT_W'(span * DIV_SCALE - 1);

	always_ff @(posedge base_freq)
	begin
		if (!rst_n)
		begin
			cnt <= '0;
			pitch_q <= '0;
			tick_q <= 1'b0;
		end
		else
		begin
			pitch_q <= pitch;
			if (pitch != pitch_q)
			begin
				// new pitch, do not wait out the old period
				cnt <= reload;
				tick_q <= 1'b0;
			end
			else if (cnt == '0)
			begin
				cnt <= reload;
				tick_q <= 1'b1;
			end
			else
			begin
				cnt <= cnt - 1'b1;
				tick_q <= 1'b0;
			end
		end
	end

	assign shift_tick = tick_q;

endmodule

//--- source/noise_lfsr.sv
module noise_lfsr
	import synth_pkg::*;
(
	input  logic base_freq,
	input  logic rst_n,
	input  logic shift_tick,
	input  logic active,
	output logic noise_bit
);

	logic [15:0] lfsr_q;
	logic feedback;

	// fibonacci taps 16, 14, 13, 11
	assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

	always_ff @(posedge base_freq)
	begin
		if (!rst_n)
			lfsr_q <= LFSR_SEED;
		else if (shift_tick && active)
			// shift left, feedback into bit 0
			lfsr_q <= {lfsr_q[14:0], feedback};
	end

	// idle notes freeze the sequence where it stopped
	assign noise_bit = lfsr_q[0];

endmodule

//--- source/envelope_control.sv
module envelope_control
	import synth_pkg::*;
(
	input  logic               base_freq,
	input  logic               rst_n,
	input  logic               note_clk,
	input  logic               note_rst,
	input  logic [1:0]         env_atk,
	input  logic [1:0]         env_dec,
	input  logic [2:0]         note_length,
	input  logic               noise_bit,
	output logic               active,
	output logic [LEVEL_W-1:0] wave_out
);

	localparam logic [LEVEL_W-1:0] LEVEL_MAX = '1;

	env_state_t state;
	logic [LEVEL_W-1:0] level;
	// sustain strobes seen so far
	logic [2:0] sus_cnt;
	logic [LEVEL_W:0] atk_sum;
	logic [LEVEL_W-1:0] atk_level;
	logic [LEVEL_W-1:0] dec_amt;
	logic [LEVEL_W-1:0] wave_q;

	// attack sum, saturating at full scale
	assign atk_sum = {1'b0, level} + {1'b0, attack_step(env_atk)};
	assign atk_level = atk_sum[LEVEL_W] ? LEVEL_MAX : atk_sum[LEVEL_W-1:0];
	assign dec_amt = decay_step(env_dec);

	always_ff @(posedge base_freq)
	begin
		if (!rst_n)
		begin
			state <= env_idle;
			level <= '0;
			sus_cnt <= '0;
			wave_q <= '0;
		end
		else
		begin
			// amplitude follows the noise, one cycle late
			wave_q <= noise_bit ? level : '0;
			if (note_rst)
			begin
				state <= env_attack;
				level <= '0;
				sus_cnt <= '0;
			end
			else if (note_clk)
			begin
				case (state)
					env_attack:
					begin
						level <= atk_level;
						if (atk_level == LEVEL_MAX)
							state <= env_sustain;
					end
					env_sustain:
					begin
						// hold for note_length+1 strobes
						if (sus_cnt == note_length)
							state <= env_decay;
						else
							sus_cnt <= sus_cnt + 3'd1;
					end
					env_decay:
					begin
						if (level <= dec_amt)
						begin
							level <= '0;
							state <= env_idle;
						end
						else
							level <= level - dec_amt;
					end
					default: ;
				endcase
			end
		end
	end

	assign active = (state != env_idle);
	assign wave_out = wave_q;

endmodule

//--- source/noise_channel.sv
module noise_channel
	import synth_pkg::*;
#(
	parameter int unsigned DIV_SCALE = 64
)
(
	input  logic               base_freq,
	input  logic               rst_n,
	input  logic [PITCH_W-1:0] note_in,
	input  logic               note_clk,
	input  logic               note_rst,
	input  logic [2:0]         note_length,
	input  logic [1:0]         env_atk,
	input  logic [1:0]         env_dec,
	input  fx_mode_t           fx_sel,
	input  logic [1:0]         fx_opt_a,
	input  logic [1:0]         fx_opt_b,
	output logic [PITCH_W-1:0] pitch,
	output logic               active,
	output logic [LEVEL_W-1:0] wave_out
);

	logic shift_tick;
	logic noise_bit;

	// effect stage, bent pitch out
	note_fx u_note_fx (
		.base_freq (base_freq),
		.rst_n     (rst_n),
		.note_in   (note_in),
		.note_clk  (note_clk),
		.note_rst  (note_rst),
		.fx_sel    (fx_sel),
		.fx_opt_a  (fx_opt_a),
		.fx_opt_b  (fx_opt_b),
		.pitch     (pitch)
	);

	// pitch to lfsr shift rate
	pitch_divider #(
		.DIV_SCALE (DIV_SCALE)
	) u_pitch_divider (
		.base_freq  (base_freq),
		.rst_n      (rst_n),
		.pitch      (pitch),
		.shift_tick (shift_tick)
	);

	noise_lfsr u_noise_lfsr (
		.base_freq  (base_freq),
		.rst_n      (rst_n),
		.shift_tick (shift_tick),
		.active     (active),
		.noise_bit  (noise_bit)
	);

	// envelope gates both the lfsr and the output
	envelope_control u_envelope_control (
		.base_freq   (base_freq),
		.rst_n       (rst_n),
		.note_clk    (note_clk),
		.note_rst    (note_rst),
		.env_atk     (env_atk),
		.env_dec     (env_dec),
		.note_length (note_length),
		.noise_bit   (noise_bit),
		.active      (active),
		.wave_out    (wave_out)
	);

endmodule

//--- sim/noise_channel_assert.sv
module noise_channel_assert
	import synth_pkg::*;
(
	input logic               base_freq,
	input logic               rst_n,
	input env_state_t         state,
	input logic [LEVEL_W-1:0] level,
	input logic               active,
	input logic [LEVEL_W-1:0] wave_out
);

	timeunit 1ns;
	timeprecision 1ps;

	// a note leaves idle only through attack
	active_start: assert property (@(posedge base_freq) disable iff (!rst_n)
		$rose(active) |-> state == env_attack)
		else $error("active rose without the envelope entering attack");

	// and gets back to idle only from decay
	active_end: assert property (@(posedge base_freq) disable iff (!rst_n)
		$fell(active) |-> $past(state) == env_decay)
		else $error("active fell from a state other than decay");

	// output is silence or the level of the cycle before
	wave_level: assert property (@(posedge base_freq) disable iff (!rst_n)
		wave_out == '0 || wave_out == $past(level))
		else $error("wave_out is neither zero nor the previous level");

	// attack saturates at full scale before sustain
	level_full: assert property (@(posedge base_freq) disable iff (!rst_n)
		state == env_sustain |-> level == 4'd15)
		else $error("envelope level below full scale during sustain");

endmodule

bind envelope_control noise_channel_assert u_env_assert (
	.base_freq (base_freq),
	.rst_n     (rst_n),
	.state     (state),
	.level     (level),
	.active    (active),
	.wave_out  (wave_out)
);

//--- sim/noise_channel_tb.sv
module noise_channel_tb
	import synth_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// samples per noise window
	localparam int WIN = 48;

	logic base_freq;
	logic rst_n;
	logic [PITCH_W-1:0] note_in;
	logic note_clk;
	logic note_rst;
	logic [2:0] note_length;
	logic [1:0] env_atk;
	logic [1:0] env_dec;
	fx_mode_t fx_sel;
	logic [1:0] fx_opt_a;
	logic [1:0] fx_opt_b;
	logic [PITCH_W-1:0] pitch;
	logic active;
	logic [LEVEL_W-1:0] wave_out;

	int seed = 54172;
	int edge_cnt;
	// bit 0 of the software lfsr, one entry per shift from the seed
	bit model_bits[256];
	bit got_bits[WIN];
	// model step where the hardware lfsr rests between notes
	int lfsr_pos;
	int atk_tab[4] = '{15, 8, 4, 2};
	int dec_tab[4] = '{15, 4, 2, 1};

	noise_channel #(.DIV_SCALE(1)) u_dut (.*);

	initial base_freq = 1'b0;
	always #5 base_freq = ~base_freq;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check(input string name, input int exp, input int act);
		if (exp != act)
			stop_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// inputs change 1 ns after the edge
	task automatic tick();
		@(posedge base_freq);
		#1;
		edge_cnt++;
	endtask

	task automatic step_note();
		note_clk = 1'b1;
		tick();
		note_clk = 1'b0;
	endtask

	task automatic start_note(input int note);
		note_in = PITCH_W'(note);
		note_rst = 1'b1;
		tick();
		note_rst = 1'b0;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (8) tick();
		rst_n = 1'b1;
		tick();
	endtask

	// strobe until the envelope goes idle, stops on the strobe edge
	task automatic end_note();
		int n;
		n = 0;
		while (active)
		begin
			if (n == 32)
				stop_run("note never ended: active still high after 32 note steps");
			repeat (3) tick();
			step_note();
			n++;
		end
	endtask

	// one bit per cycle, lfsr shifts every cycle at pitch 63
	task automatic sample_noise(input string name);
		for (int j = 0; j < WIN; j++)
		begin
			tick();
			if (wave_out != 0 && wave_out != 15)
				stop_run($sformatf("Fail %s: expected 0 or 15, actual %0d", name, wave_out));
			got_bits[j] = (wave_out == 15);
		end
	endtask

	task automatic test_envelope();
		int lv[$];
		int lvl;
		int prev;
		int bound;
		apply_reset();
		check("reset active", 0, int'(active));
		check("reset wave_out", 0, int'(wave_out));
		env_atk = 2'($random(seed));
		env_dec = 2'($random(seed));
		note_length = 3'($random(seed));
		// expected level after each note step
		lvl = 0;
		while (lvl < 15)
		begin
			lvl = (lvl + atk_tab[env_atk] > 15) ? 15 : lvl + atk_tab[env_atk];
			lv.push_back(lvl);
		end
		repeat (int'(note_length) + 1) lv.push_back(15);
		while (lvl > 0)
		begin
			lvl = (lvl <= dec_tab[env_dec]) ? 0 : lvl - dec_tab[env_dec];
			lv.push_back(lvl);
		end
		start_note($random(seed) & 63);
		prev = 0;
		foreach (lv[k])
		begin
			check("envelope active", 1, int'(active));
			// wave_out lags by a cycle, so either neighbor level is allowed
			bound = (lv[k] > prev) ? lv[k] : prev;
			step_note();
			repeat (19)
			begin
				if (int'(wave_out) > bound)
					stop_run($sformatf("Fail envelope: expected at most %0d, actual %0d",
						bound, wave_out));
				tick();
			end
			prev = lv[k];
		end
		check("envelope active after last step", 0, int'(active));
	endtask

	task automatic test_noise();
		int off;
		int e0;
		bit hit;
		apply_reset();
		env_atk = 2'd0;
		env_dec = 2'd0;
		note_length = 3'd0;
		fx_sel = fx_none;
		start_note(63);
		step_note();
		// let the divider settle on the new pitch
		repeat (4) tick();
		e0 = edge_cnt + 1;
		sample_noise("noise");
		// window position in the model sequence
		off = -1;
		for (int o = 0; o < 64 && off < 0; o++)
		begin
			hit = 1'b1;
			for (int j = 0; j < WIN; j++)
				if (got_bits[j] != model_bits[o + j])
					hit = 1'b0;
			if (hit)
				off = o;
		end
		if (off < 0)
			stop_run("noise: sampled bits match no stretch of the LFSR sequence");
		end_note();
		lfsr_pos = off + edge_cnt - e0 + 1;
	endtask

	task automatic test_hold();
		int r;
		int e0;
		repeat (200) tick();
		check("idle active", 0, int'(active));
		start_note(63);
		r = edge_cnt;
		step_note();
		repeat (4) tick();
		e0 = edge_cnt + 1;
		sample_noise("hold");
		// first shift of the new note is at edge r+1
		for (int j = 0; j < WIN; j++)
			check("hold noise bit", int'(model_bits[lfsr_pos + e0 + j - r - 1]),
				int'(got_bits[j]));
		end_note();
	endtask

	task automatic test_porta();
		fx_sel = fx_none;
		fx_opt_a = 2'd0;
		start_note(10);
		fx_sel = fx_porta;
		tick();
		note_in = 6'd14;
		tick();
		check("porta hold", 10, int'(pitch));
		for (int k = 1; k <= 6; k++)
		begin
			step_note();
			check("porta", (10 + k > 14) ? 14 : 10 + k, int'(pitch));
		end
	endtask

	task automatic run_slide(input string name, input int start, input bit up);
		int exp;
		int cnt;
		fx_sel = fx_slide;
		fx_opt_a = 2'd1;
		fx_opt_b = {1'b0, up};
		start_note(start);
		exp = start;
		cnt = 0;
		repeat (8)
		begin
			step_note();
			if (cnt == int'(fx_opt_a))
			begin
				cnt = 0;
				if (up)
					exp = (exp == 63) ? 63 : exp + 1;
				else
					exp = (exp == 0) ? 0 : exp - 1;
			end
			else
				cnt++;
			check(name, exp, int'(pitch));
		end
	endtask

	task automatic run_vibrato(input string name, input int note);
		int offs[4] = '{2, 0, -2, 0};
		int exp;
		fx_sel = fx_vibrato;
		fx_opt_a = 2'd0;
		fx_opt_b = 2'd2;
		start_note(note);
		for (int k = 0; k < 8; k++)
		begin
			step_note();
			exp = note + offs[k % 4];
			exp = (exp < 0) ? 0 : ((exp > 63) ? 63 : exp);
			check(name, exp, int'(pitch));
		end
	endtask

	initial
	begin
		logic [15:0] s;
		rst_n = 1'b0;
		note_in = '0;
		note_clk = 1'b0;
		note_rst = 1'b0;
		note_length = '0;
		env_atk = '0;
		env_dec = '0;
		fx_sel = fx_none;
		fx_opt_a = '0;
		fx_opt_b = '0;
		edge_cnt = 0;
		// software lfsr, taps 15 13 12 10 into bit 0
		s = LFSR_SEED;
		for (int i = 0; i < 256; i++)
		begin
			model_bits[i] = s[0];
			s = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
		end
		test_envelope();
		test_noise();
		test_hold();
		test_porta();
		run_slide("slide up", 61, 1'b1);
		run_slide("slide down", 1, 1'b0);
		run_vibrato("vibrato", 30);
		run_vibrato("vibrato clamp", 1);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- flist.f
source/synth_pkg.sv
source/note_fx.sv
source/pitch_divider.sv
source/noise_lfsr.sv
source/envelope_control.sv
source/noise_channel.sv
sim/noise_channel_assert.sv
sim/noise_channel_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
	--top-module noise_channel_tb -o noise_channel_sim \
	&& ./obj_dir/noise_channel_sim || exit 1
